/* design/alu.sv */
module alu
    import cpu_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount comes from a, b is the value shifted
    assign shamt = a[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                y = a + b;
            end
            alu_sub: begin
                y = a - b;
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_nor: begin
                y = ~(a | b);
            end
            alu_slt: begin
                y = {31'd0, lt_signed};
            end
            alu_sltu: begin
                y = {31'd0, lt_unsigned};
            end
            alu_sll: begin
                y = b << shamt;
            end
            alu_srl: begin
                y = b >> shamt;
            end
            alu_sra: begin
                y = word_t'($signed(b) >>> shamt);
            end
            alu_lui: begin
                y = {b[15:0], 16'd0};
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* design/branch_cmp.sv */
module branch_cmp
    import cpu_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  cmp_op_t op,
    output logic    cond_true
);

    logic a_zero;
    logic a_neg;

    // single operand tests only look at a
    assign a_zero = (a == '0);
    assign a_neg  = a[31];

    always_comb begin
        case (op)
            cmp_eq:  cond_true = (a == b);
            cmp_ne:  cond_true = (a != b);
            cmp_lez: cond_true = a_neg | a_zero;
            cmp_gtz: cond_true = ~a_neg & ~a_zero;
            cmp_ltz: cond_true = a_neg;
            cmp_gez: cond_true = ~a_neg;
            default: cond_true = 1'b0;
        endcase
    end

endmodule

/* design/branch_resolve.sv */
module branch_resolve
    import cpu_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  branch_kind_t kind,
    input  logic         cond_true,
    input  logic         pred_taken,
    input  word_t        pred_target,
    input  word_t        pc,
    input  word_t        br_target,
    input  word_t        reg_target,
    output logic         redirect,
    output word_t        target_pc
);

    word_t fall_through;

    // not-taken path resumes after the delay slot
    assign fall_through = pc + link_offset;

    always_comb begin
        redirect  = 1'b0;
        target_pc = '0;
        case (kind)
            br_cond: begin
                if (cond_true && !pred_taken) begin
                    redirect  = 1'b1;
                    target_pc = br_target;
                end else if (!cond_true && pred_taken) begin
                    // fetch went down the taken path, pull it back
                    redirect  = 1'b1;
                    target_pc = fall_through;
                end
            end
            br_jump: begin
                // target is static, only a missed prediction matters
                if (!pred_taken) begin
                    redirect  = 1'b1;
                    target_pc = br_target;
                end
            end
            br_jump_reg: begin
                // register target must match what fetch guessed
                if (!pred_taken || (pred_target != reg_target)) begin
                    redirect  = 1'b1;
                    target_pc = reg_target;
                end
            end
            default: begin
                redirect  = 1'b0;
                target_pc = '0;
            end
        endcase
    end

endmodule

/* design/cpu_types_pkg.sv */
package cpu_types_pkg;

    // data path widths
    localparam int word_width = 32;
    localparam int reg_addr_width = 5;

    // one data word or byte address
    typedef logic [word_width-1:0] word_t;

    // architectural register index
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // return address sits two instructions past the branch (delay slot)
    localparam word_t link_offset = 32'd8;

endpackage

/* design/exec_ops_pkg.sv */
package exec_ops_pkg;

    // alu operation select
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_and  = 4'd2;
    localparam alu_op_t alu_or   = 4'd3;
    localparam alu_op_t alu_xor  = 4'd4;
    localparam alu_op_t alu_nor  = 4'd5;
    localparam alu_op_t alu_slt  = 4'd6;
    localparam alu_op_t alu_sltu = 4'd7;
    localparam alu_op_t alu_sll  = 4'd8;
    localparam alu_op_t alu_srl  = 4'd9;
    localparam alu_op_t alu_sra  = 4'd10;
    localparam alu_op_t alu_lui  = 4'd11;

    // branch condition select
    typedef logic [2:0] cmp_op_t;

    localparam cmp_op_t cmp_eq  = 3'd0;
    localparam cmp_op_t cmp_ne  = 3'd1;
    localparam cmp_op_t cmp_lez = 3'd2;
    localparam cmp_op_t cmp_gtz = 3'd3;
    localparam cmp_op_t cmp_ltz = 3'd4;
    localparam cmp_op_t cmp_gez = 3'd5;

    // instruction class seen by execute
    typedef logic [1:0] exe_type_t;

    localparam exe_type_t exe_alu    = 2'd0;
    localparam exe_type_t exe_load   = 2'd1;
    localparam exe_type_t exe_store  = 2'd2;
    localparam exe_type_t exe_branch = 2'd3;

    // how the branch target is formed
    typedef logic [1:0] branch_kind_t;

    localparam branch_kind_t br_cond     = 2'd0;
    localparam branch_kind_t br_jump     = 2'd1;
    localparam branch_kind_t br_jump_reg = 2'd2;

endpackage

/* design/execute_stage.sv */
module execute_stage
    import cpu_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  exe_type_t    exe_type,
    input  branch_kind_t branch_kind,
    input  alu_op_t      alu_op,
    input  cmp_op_t      cmp_op,
    input  word_t        pc,
    input  word_t        num_a,
    input  word_t        num_b,
    input  word_t        mem_offset,
    input  word_t        br_target,
    input  logic         pred_taken,
    input  word_t        pred_target,
    input  logic         wr_reg_need,
    input  reg_addr_t    wr_reg_addr,
    output logic         out_valid,
    output logic         mem_read_en,
    output logic         mem_write_en,
    output logic         wr_reg_en,
    output reg_addr_t    wr_reg_dst,
    output word_t        result,
    output word_t        mem_addr,
    output word_t        write_data,
    output logic         redirect_en,
    output word_t        redirect_pc
);

    word_t alu_y;
    word_t link_pc;
    word_t result_next;
    word_t addr_next;
    word_t resolve_pc;
    logic  cond_true;
    logic  resolve_redirect;
    logic  is_branch;
    logic  take_redirect;

    alu u_alu (
        .a  (num_a),
        .b  (num_b),
        .op (alu_op),
        .y  (alu_y)
    );

    branch_cmp u_branch_cmp (
        .a         (num_a),
        .b         (num_b),
        .op        (cmp_op),
        .cond_true (cond_true)
    );

    branch_resolve u_branch_resolve (
        .kind        (branch_kind),
        .cond_true   (cond_true),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .pc          (pc),
        .br_target   (br_target),
        .reg_target  (num_a),
        .redirect    (resolve_redirect),
        .target_pc   (resolve_pc)
    );

    assign is_branch = (exe_type == exe_branch);

    // branches write the return address instead of an alu value
    assign link_pc     = pc + link_offset;
    assign result_next = is_branch ? link_pc : alu_y;

    // base register plus sign-extended offset from decode
    assign addr_next = mem_offset + num_b;

    // resolver ignores the class, so only branches may redirect
    assign take_redirect = in_valid & is_branch & resolve_redirect;

    // ex/mem boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            wr_reg_en    <= 1'b0;
            redirect_en  <= 1'b0;
            wr_reg_dst   <= '0;
            result       <= '0;
            mem_addr     <= '0;
            write_data   <= '0;
            redirect_pc  <= '0;
        end else begin
            out_valid    <= in_valid;
            mem_read_en  <= in_valid & (exe_type == exe_load);
            mem_write_en <= in_valid & (exe_type == exe_store);
            wr_reg_en    <= in_valid & wr_reg_need;
            redirect_en  <= take_redirect;
            wr_reg_dst   <= wr_reg_addr;
            result       <= result_next;
            mem_addr     <= addr_next;
            write_data   <= num_a;
            redirect_pc  <= take_redirect ? resolve_pc : '0;
        end
    end

endmodule

/* execute_stage.f */
design/cpu_types_pkg.sv
design/exec_ops_pkg.sv
design/alu.sv
design/branch_cmp.sv
design/branch_resolve.sv
design/execute_stage.sv
verification/execute_stage_checker.sv
verification/execute_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module execute_stage_tb \
    -f execute_stage.f \
    -o execute_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/execute_stage_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

/* verification/execute_stage_checker.sv */
module execute_stage_checker (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic mem_read_en,
    input logic mem_write_en,
    input logic wr_reg_en,
    input logic redirect_en
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run
    int assert_errors = 0;

    a_redirect_valid: assert property (
        @(posedge clk) disable iff (rst) redirect_en |-> out_valid
    ) else begin
        $error("redirect_en high while out_valid is low");
        assert_errors++;
    end

    // a slot is either a load or a store, never both
    a_mem_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read_en && mem_write_en)
    ) else begin
        $error("mem_read_en and mem_write_en high together");
        assert_errors++;
    end

    a_controls_valid: assert property (
        @(posedge clk) disable iff (rst)
        (wr_reg_en || mem_read_en || mem_write_en || redirect_en) |-> out_valid
    ) else begin
        $error("control output high while out_valid is low");
        assert_errors++;
    end

    a_reset_clears: assert property (
        @(posedge clk)
        rst |=> !(out_valid || mem_read_en || mem_write_en || wr_reg_en || redirect_en)
    ) else begin
        $error("control output high in the cycle after reset");
        assert_errors++;
    end

endmodule

bind execute_stage execute_stage_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .out_valid    (out_valid),
    .mem_read_en  (mem_read_en),
    .mem_write_en (mem_write_en),
    .wr_reg_en    (wr_reg_en),
    .redirect_en  (redirect_en)
);

/* verification/execute_stage_tb.sv */
module execute_stage_tb
    import cpu_types_pkg::*;
    import exec_ops_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int alu_reps = 6;
    localparam int mem_reps = 4;
    localparam int b2b_len = 6;
    localparam int num_instrs = 1 + 12 * alu_reps + 2 * mem_reps + 24 + 5 + b2b_len;
    // at most three cycles per instruction, plus reset and slack
    localparam int watchdog_ns = (3 * num_instrs + 40) * clk_period;

    typedef struct {
        logic         valid;
        exe_type_t    t;
        branch_kind_t k;
        alu_op_t      aop;
        cmp_op_t      cop;
        word_t        pcv;
        word_t        a;
        word_t        b;
        word_t        off;
        word_t        tgt;
        logic         pt;
        word_t        ptgt;
        logic         need;
        reg_addr_t    dst;
    } instr_t;

    typedef struct {
        logic      valid;
        logic      rd;
        logic      wr;
        logic      wren;
        reg_addr_t dst;
        word_t     result;
        word_t     addr;
        word_t     wdata;
        logic      redir;
        word_t     rpc;
    } expect_t;

    logic         clk;
    logic         rst;
    logic         in_valid;
    exe_type_t    exe_type;
    branch_kind_t branch_kind;
    alu_op_t      alu_op;
    cmp_op_t      cmp_op;
    word_t        pc;
    word_t        num_a;
    word_t        num_b;
    word_t        mem_offset;
    word_t        br_target;
    logic         pred_taken;
    word_t        pred_target;
    logic         wr_reg_need;
    reg_addr_t    wr_reg_addr;
    logic         out_valid;
    logic         mem_read_en;
    logic         mem_write_en;
    logic         wr_reg_en;
    reg_addr_t    wr_reg_dst;
    word_t        result;
    word_t        mem_addr;
    word_t        write_data;
    logic         redirect_en;
    word_t        redirect_pc;

    expect_t exp_q[$];
    word_t   lcg_state;
    int      errors;
    int      checks;

    execute_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: tests did not finish within %0d ns", watchdog_ns);
        $display("Checks failed");
        $finish;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        logic [32:0] diff;
        logic [4:0]  s;
        word_t       fill;
        s = a[4:0];
        diff = {1'b0, a} - {1'b0, b};
        fill = b[31] ? ~(32'hffff_ffff >> s) : 32'd0;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~a & ~b;
            // flipped sign bits turn signed order into unsigned order
            alu_slt:  return word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
            alu_sltu: return word_t'(diff[32]);
            alu_sll:  return b * (32'd1 << s);
            alu_srl:  return b >> s;
            alu_sra:  return (b >> s) | fill;
            alu_lui:  return b << 16;
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_cond(input cmp_op_t op, input word_t a, input word_t b);
        case (op)
            cmp_eq:  return a == b;
            cmp_ne:  return a != b;
            cmp_lez: return $signed(a) <= 0;
            cmp_gtz: return $signed(a) > 0;
            cmp_ltz: return $signed(a) < 0;
            cmp_gez: return $signed(a) >= 0;
            default: return 1'b0;
        endcase
    endfunction

    function automatic expect_t predict(input instr_t i);
        expect_t e;
        logic    c;
        logic    redir;
        word_t   dest;
        c = model_cond(i.cop, i.a, i.b);
        redir = 1'b0;
        dest = '0;
        if (i.t == exe_branch) begin
            case (i.k)
                br_cond: begin
                    redir = (c != i.pt);
                    dest = c ? i.tgt : i.pcv + 32'd8;
                end
                br_jump: begin
                    redir = !i.pt;
                    dest = i.tgt;
                end
                br_jump_reg: begin
                    redir = !i.pt || (i.ptgt != i.a);
                    dest = i.a;
                end
                default: redir = 1'b0;
            endcase
        end
        e.valid = i.valid;
        e.rd = i.valid && (i.t == exe_load);
        e.wr = i.valid && (i.t == exe_store);
        e.wren = i.valid && i.need;
        e.dst = i.dst;
        e.result = (i.t == exe_branch) ? i.pcv + 32'd8 : model_alu(i.aop, i.a, i.b);
        e.addr = i.off + i.b;
        e.wdata = i.a;
        e.redir = i.valid && redir;
        e.rpc = e.redir ? dest : '0;
        return e;
    endfunction

    function automatic instr_t random_instr();
        instr_t i;
        word_t  r;
        r = lcg_next();
        i.valid = 1'b1;
        i.t = exe_alu;
        i.k = r[16] ? br_jump : br_cond;
        i.aop = alu_add;
        i.cop = cmp_op_t'(r[22:20] % 3'd6);
        i.pcv = lcg_next() & 32'hffff_fffc;
        i.a = lcg_next();
        i.b = lcg_next();
        i.off = lcg_next();
        i.tgt = lcg_next() & 32'hffff_fffc;
        i.pt = r[24];
        i.ptgt = lcg_next() & 32'hffff_fffc;
        i.need = r[25];
        i.dst = r[31:27];
        return i;
    endfunction

    // force the operands so the condition comes out as wanted
    function automatic instr_t set_condition(input instr_t i, input logic want, input logic zero);
        instr_t o;
        o = i;
        case (i.cop)
            cmp_eq:  o.b = want ? i.a : ~i.a;
            cmp_ne:  o.b = want ? ~i.a : i.a;
            cmp_lez: o.a = want ? {1'b1, i.a[30:0]} : {1'b0, i.a[30:0] | 31'd1};
            cmp_gtz: o.a = want ? {1'b0, i.a[30:0] | 31'd1} : {1'b1, i.a[30:0]};
            cmp_ltz: o.a = {want, i.a[30:0]};
            default: o.a = {~want, i.a[30:0]};
        endcase
        // zero is the edge case for lez and gtz
        if (zero && ((i.cop == cmp_lez && want) || (i.cop == cmp_gtz && !want))) begin
            o.a = '0;
        end
        return o;
    endfunction

    task automatic compare(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic issue(input instr_t i);
        exp_q.push_back(predict(i));
        @(posedge clk);
        in_valid <= i.valid;
        exe_type <= i.t;
        branch_kind <= i.k;
        alu_op <= i.aop;
        cmp_op <= i.cop;
        pc <= i.pcv;
        num_a <= i.a;
        num_b <= i.b;
        mem_offset <= i.off;
        br_target <= i.tgt;
        pred_taken <= i.pt;
        pred_target <= i.ptgt;
        wr_reg_need <= i.need;
        wr_reg_addr <= i.dst;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic check_next(input string tag);
        expect_t e;
        @(negedge clk);
        if (exp_q.size() == 0) begin
            errors++;
            $display("no expected instruction left to check for %s", tag);
        end else begin
            e = exp_q.pop_front();
            compare(word_t'(out_valid), word_t'(e.valid), {tag, " out_valid"});
            compare(word_t'(mem_read_en), word_t'(e.rd), {tag, " mem_read_en"});
            compare(word_t'(mem_write_en), word_t'(e.wr), {tag, " mem_write_en"});
            compare(word_t'(wr_reg_en), word_t'(e.wren), {tag, " wr_reg_en"});
            compare(word_t'(redirect_en), word_t'(e.redir), {tag, " redirect_en"});
            compare(redirect_pc, e.rpc, {tag, " redirect_pc"});
            if (e.valid) begin
                compare(word_t'(wr_reg_dst), word_t'(e.dst), {tag, " wr_reg_dst"});
                compare(result, e.result, {tag, " result"});
                compare(mem_addr, e.addr, {tag, " mem_addr"});
                compare(write_data, e.wdata, {tag, " write_data"});
            end
        end
    endtask

    task automatic reset_and_idle();
        instr_t i;
        @(negedge clk);
        compare(word_t'(out_valid), 32'd0, "reset out_valid");
        compare(word_t'(mem_read_en), 32'd0, "reset mem_read_en");
        compare(word_t'(mem_write_en), 32'd0, "reset mem_write_en");
        compare(word_t'(wr_reg_en), 32'd0, "reset wr_reg_en");
        compare(word_t'(redirect_en), 32'd0, "reset redirect_en");
        compare(word_t'(wr_reg_dst), 32'd0, "reset wr_reg_dst");
        compare(result, 32'd0, "reset result");
        compare(mem_addr, 32'd0, "reset mem_addr");
        compare(write_data, 32'd0, "reset write_data");
        compare(redirect_pc, 32'd0, "reset redirect_pc");
        // invalid slot dressed as a mispredicted jump that writes a register
        i = random_instr();
        i.valid = 1'b0;
        i.t = exe_branch;
        i.k = br_jump;
        i.pt = 1'b0;
        i.need = 1'b1;
        issue(i);
        idle_cycle();
        check_next("idle slot");
    endtask

    task automatic alu_sweep();
        instr_t i;
        for (int rep = 0; rep < alu_reps; rep++) begin
            for (int op = 0; op < 12; op++) begin
                i = random_instr();
                i.aop = alu_op_t'(op);
                issue(i);
                idle_cycle();
                check_next($sformatf("alu op %0d rep %0d", op, rep));
            end
        end
    endtask

    task automatic load_store_pass();
        instr_t i;
        for (int rep = 0; rep < 2 * mem_reps; rep++) begin
            i = random_instr();
            i.t = rep[0] ? exe_store : exe_load;
            i.need = !rep[0];
            i.off = {{16{i.off[15]}}, i.off[15:0]};
            issue(i);
            idle_cycle();
            check_next($sformatf("memory access %0d", rep));
        end
    endtask

    task automatic cond_branch_table();
        instr_t i;
        for (int cop = 0; cop < 6; cop++) begin
            for (int want = 0; want < 2; want++) begin
                for (int pt = 0; pt < 2; pt++) begin
                    i = random_instr();
                    i.t = exe_branch;
                    i.k = br_cond;
                    i.cop = cmp_op_t'(cop);
                    i.pt = pt[0];
                    i = set_condition(i, want[0], pt[0]);
                    issue(i);
                    idle_cycle();
                    check_next($sformatf("cond op %0d cond %0d pred %0d", cop, want, pt));
                end
            end
        end
    endtask

    // j miss, j hit, jr miss, jr hit, jr with wrong target
    task automatic jump_cases();
        instr_t i;
        for (int c = 0; c < 5; c++) begin
            i = random_instr();
            i.t = exe_branch;
            i.k = (c < 2) ? br_jump : br_jump_reg;
            i.pt = (c != 0) && (c != 2);
            i.ptgt = (c == 4) ? i.a ^ 32'h40 : i.a;
            issue(i);
            idle_cycle();
            check_next($sformatf("jump case %0d", c));
        end
    endtask

    task automatic back_to_back();
        instr_t i;
        for (int n = 0; n < b2b_len; n++) begin
            i = random_instr();
            i.t = exe_type_t'((n * 3) % 4);
            i.k = branch_kind_t'(n % 3);
            i.aop = alu_op_t'(n);
            i.need = 1'b1;
            i.dst = reg_addr_t'(n + 1);
            issue(i);
            if (n > 0) begin
                check_next($sformatf("back-to-back slot %0d", n - 1));
            end
        end
        idle_cycle();
        check_next($sformatf("back-to-back slot %0d", b2b_len - 1));
    endtask

    initial begin
        errors = 0;
        checks = 0;
        lcg_state = 32'd69;
        rst <= 1'b1;
        in_valid <= 1'b0;
        exe_type <= exe_alu;
        branch_kind <= br_cond;
        alu_op <= alu_add;
        cmp_op <= cmp_eq;
        pc <= '0;
        num_a <= '0;
        num_b <= '0;
        mem_offset <= '0;
        br_target <= '0;
        pred_taken <= 1'b0;
        pred_target <= '0;
        wr_reg_need <= 1'b0;
        wr_reg_addr <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_and_idle();
        alu_sweep();
        load_store_pass();
        cond_branch_table();
        jump_cases();
        back_to_back();
        $display("checks: %0d, value errors: %0d, assertion errors: %0d",
            checks, errors, uut.u_checker.assert_errors);
        if (errors == 0 && uut.u_checker.assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
